// File: logic/dm_consts.svh
// Debug module constants
`ifndef DM_CONSTS_SVH
`define DM_CONSTS_SVH

// Hart register access
`define DM_XLEN            64
`define DM_PREG_BITS       6
`define DM_LREG_BITS       5

// Program and data buffer
`define DM_PROGBUF_WORDS   4
`define DM_DATA_WORDS      2
`define DM_BUF_WORDS       6
`define DM_FETCH_ADDR_BITS 3
`define DM_EBREAK          32'h0010_0073

// DMI bus
`define DM_DMI_ADDR_BITS   7
`define DM_DMI_DATA_BITS   32

// Abstract command regno window for the GPRs
`define DM_REGNO_GPR_FIRST 16'h1000
`define DM_REGNO_GPR_LAST  16'h101f

`endif

// File: logic/dmi_pkg.sv
// Debugger side types
`include "dm_consts.svh"

package dmi_pkg;

    typedef logic [`DM_DMI_ADDR_BITS-1:0] dmi_addr_t;
    typedef logic [`DM_DMI_DATA_BITS-1:0] dmi_data_t;

    typedef enum logic [1:0] {
        dmi_nop   = 2'd0,
        dmi_read  = 2'd1,
        dmi_write = 2'd2
    } dmi_op_t;

    // Response codes reuse the op field
    parameter dmi_op_t dmi_success = dmi_nop;
    parameter dmi_op_t dmi_failed  = dmi_write;

    typedef enum logic [`DM_DMI_ADDR_BITS-1:0] {
        reg_data0      = 7'h04,
        reg_data1      = 7'h05,
        reg_dmcontrol  = 7'h10,
        reg_dmstatus   = 7'h11,
        reg_hartinfo   = 7'h12,
        reg_abstractcs = 7'h16,
        reg_command    = 7'h17,
        reg_progbuf0   = 7'h20,
        reg_progbuf1   = 7'h21,
        reg_progbuf2   = 7'h22,
        reg_progbuf3   = 7'h23,
        reg_sbcs       = 7'h38
    } dm_reg_e;

    typedef enum logic [1:0] {st_idle, st_respond, st_cmd_busy} dm_state_e;

endpackage

// File: logic/hart_pkg.sv
// Hart side types
`include "dm_consts.svh"

package hart_pkg;

    // Register values and numbers
    typedef logic [`DM_XLEN-1:0]      xlen_t;
    typedef logic [`DM_LREG_BITS-1:0] lreg_t;
    typedef logic [`DM_PREG_BITS-1:0] preg_t;

    // Word index into the program and data buffer
    typedef logic [`DM_FETCH_ADDR_BITS-1:0] buf_idx_t;

    // Abstract command error codes
    typedef enum logic [2:0] {
        cmderr_none          = 3'd0,
        cmderr_not_supported = 3'd2,
        cmderr_halt_resume   = 3'd4
    } cmderr_e;

endpackage

// File: logic/dm_buffer_mem.sv
// Program and data buffer
`timescale 1ns/1ps
`include "dm_consts.svh"

module dm_buffer_mem (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               dmi_buf_we_i,
    input  hart_pkg::buf_idx_t dmi_buf_idx_i,
    input  dmi_pkg::dmi_data_t dmi_buf_wdata_i,
    input  logic               cmd_buf_we_i,
    input  logic               cmd_buf_wide_i,
    input  hart_pkg::xlen_t    cmd_buf_wdata_i,
    input  logic               fetch_en_i,
    input  hart_pkg::buf_idx_t fetch_addr_i,
    output dmi_pkg::dmi_data_t buf_rdata_o,
    output hart_pkg::xlen_t    cmd_data_in_o,
    output dmi_pkg::dmi_data_t fetch_rdata_o
);

    // Progbuf words first, data words after them
    localparam int unsigned data_base = `DM_PROGBUF_WORDS;

    dmi_pkg::dmi_data_t words_q [`DM_BUF_WORDS];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `DM_BUF_WORDS; i++) begin
                words_q[i] <= '0;
            end
        end else if (cmd_buf_we_i) begin   // Register read result wins
            words_q[data_base] <= cmd_buf_wdata_i[31:0];
            if (cmd_buf_wide_i) begin
                words_q[data_base + 1] <= cmd_buf_wdata_i[63:32];
            end
        end else if (dmi_buf_we_i && dmi_buf_idx_i < `DM_BUF_WORDS) begin
            words_q[dmi_buf_idx_i] <= dmi_buf_wdata_i;
        end
    end

    assign buf_rdata_o   = (dmi_buf_idx_i < `DM_BUF_WORDS) ? words_q[dmi_buf_idx_i] : '0;
    assign cmd_data_in_o = {words_q[data_base + 1], words_q[data_base]};

    // Past the last word the hart sees ebreak
    always_comb begin
        if (!fetch_en_i) begin
            fetch_rdata_o = '0;
        end else if (fetch_addr_i >= `DM_BUF_WORDS) begin
            fetch_rdata_o = `DM_EBREAK;
        end else begin
            fetch_rdata_o = words_q[fetch_addr_i];
        end
    end

endmodule

// File: logic/dm_abstract_cmd.sv
// Abstract register access engine
`timescale 1ns/1ps

module dm_abstract_cmd (
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            cmd_start_i,
    input  hart_pkg::lreg_t cmd_lreg_i,
    input  logic            cmd_write_i,
    input  logic            cmd_wide_i,
    input  hart_pkg::xlen_t cmd_data_in_i,
    input  hart_pkg::preg_t rnm_read_resp_i,
    input  hart_pkg::xlen_t rf_rdata_i,
    output logic            cmd_done_o,
    output logic            rnm_read_en_o,
    output hart_pkg::lreg_t rnm_read_reg_o,
    output logic            rf_en_o,
    output hart_pkg::preg_t rf_preg_o,
    output logic            rf_we_o,
    output hart_pkg::xlen_t rf_wdata_o,
    output logic            cmd_buf_we_o,
    output logic            cmd_buf_wide_o,
    output hart_pkg::xlen_t cmd_buf_wdata_o
);

    logic               rename_q;   // Rename lookup cycle
    logic               access_q;   // Register file cycle
    logic               start;
    hart_pkg::lreg_t    lreg_q;
    hart_pkg::preg_t    preg_q;
    logic               write_q, wide_q;
    dmi_pkg::dmi_data_t data_lo;

    // Only one command in flight
    assign start = cmd_start_i && !rename_q && !access_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rename_q <= 1'b0;
            access_q <= 1'b0;
        end else begin
            rename_q <= start;
            access_q <= rename_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            lreg_q  <= cmd_lreg_i;
            write_q <= cmd_write_i;
            wide_q  <= cmd_wide_i;
        end
        if (rename_q) preg_q <= rnm_read_resp_i;   // Mapping answered in the same cycle
    end

    assign rnm_read_en_o  = rename_q;
    assign rnm_read_reg_o = lreg_q;

    // 32 bit writes take data0 and zero the upper half
    assign data_lo    = cmd_data_in_i[31:0];
    assign rf_preg_o  = preg_q;
    assign rf_en_o    = access_q && !write_q;
    assign rf_we_o    = access_q && write_q;
    assign rf_wdata_o = wide_q ? cmd_data_in_i : {32'b0, data_lo};

    // Read result goes back to data0, and data1 when wide
    assign cmd_buf_we_o    = access_q && !write_q;
    assign cmd_buf_wide_o  = wide_q;
    assign cmd_buf_wdata_o = rf_rdata_i;

    assign cmd_done_o = access_q;

endmodule

// File: logic/dm_dmi_regs.sv
// DMI register front end
`timescale 1ns/1ps
`include "dm_consts.svh"

module dm_dmi_regs (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               req_valid_i,
    input  dmi_pkg::dmi_addr_t req_addr_i,
    input  dmi_pkg::dmi_data_t req_data_i,
    input  dmi_pkg::dmi_op_t   req_op_i,
    input  logic               resp_ready_i,
    input  logic               resume_ack_i,
    input  logic               running_i,
    input  logic               halted_i,
    input  logic               havereset_i,
    input  logic               unavail_i,
    input  logic               cmd_done_i,
    input  dmi_pkg::dmi_data_t buf_rdata_i,
    output logic               req_ready_o,
    output logic               resp_valid_o,
    output dmi_pkg::dmi_data_t resp_data_o,
    output dmi_pkg::dmi_op_t   resp_op_o,
    output logic               halt_request_o,
    output logic               resume_request_o,
    output logic               hart_reset_o,
    output logic               cmd_start_o,
    output hart_pkg::lreg_t    cmd_lreg_o,
    output logic               cmd_write_o,
    output logic               cmd_wide_o,
    output logic               dmi_buf_we_o,
    output hart_pkg::buf_idx_t dmi_buf_idx_o,
    output dmi_pkg::dmi_data_t dmi_buf_wdata_o
);

    dmi_pkg::dm_state_e state_q;
    logic               haltreq_q, hartreset_q, dmactive_q, resumereq_q;
    logic               resumeack_q, havereset_q, unavail_q;   // Sticky status
    logic               cmd_start_q;
    hart_pkg::cmderr_e  cmderr_q;
    dmi_pkg::dmi_data_t req_data_q;
    dmi_pkg::dmi_data_t resp_data_q;
    dmi_pkg::dmi_op_t   resp_op_q;
    dmi_pkg::dmi_data_t rd_data, dmstatus, abstractcs;
    logic               accept, is_rd, is_wr, is_buf, dmctl_wr, resume_wr, cmd_bad;

    assign accept = (state_q == dmi_pkg::st_idle) && req_valid_i;
    assign is_rd  = req_op_i == dmi_pkg::dmi_read;
    assign is_wr  = req_op_i == dmi_pkg::dmi_write;
    assign is_buf = req_addr_i inside {dmi_pkg::reg_data0, dmi_pkg::reg_data1,
                                       dmi_pkg::reg_progbuf0, dmi_pkg::reg_progbuf1,
                                       dmi_pkg::reg_progbuf2, dmi_pkg::reg_progbuf3};

    // resumereq only counts when no halt request is pending or written
    assign dmctl_wr  = accept && is_wr && (req_addr_i == dmi_pkg::reg_dmcontrol);
    assign resume_wr = dmctl_wr && req_data_i[30] && !req_data_i[31] && !haltreq_q;

    // cmdtype, regno window, aarsize and postexec
    assign cmd_bad = (req_data_i[31:24] != 8'd0)
                  || (req_data_i[15:0] < `DM_REGNO_GPR_FIRST)
                  || (req_data_i[15:0] > `DM_REGNO_GPR_LAST)
                  || !(req_data_i[22:20] inside {3'd2, 3'd3})
                  || req_data_i[18];

    assign dmstatus = {12'b0, {2{havereset_q}}, {2{resumeack_q}}, 2'b0, {2{unavail_q}},
                       {2{running_i}}, {2{halted_i}}, 1'b1, 3'b0, 4'd3};
    assign abstractcs = {3'b0, 5'(`DM_PROGBUF_WORDS), 13'b0, cmderr_q, 4'b0,
                         4'(`DM_DATA_WORDS)};

    always_comb begin
        rd_data = '0;   // hartinfo, command and holes read zero
        case (req_addr_i)
            dmi_pkg::reg_dmcontrol:  rd_data = {haltreq_q, 1'b0, hartreset_q, 28'b0, dmactive_q};
            dmi_pkg::reg_dmstatus:   rd_data = dmstatus;
            dmi_pkg::reg_abstractcs: rd_data = abstractcs;
            default: begin
                if (is_buf) rd_data = buf_rdata_i;
            end
        endcase
    end

    // Buffer write port; data0/1 map to words 4 and 5
    assign dmi_buf_we_o    = accept && is_wr && is_buf;
    assign dmi_buf_idx_o   = req_addr_i[5] ? {1'b0, req_addr_i[1:0]} : {2'b10, req_addr_i[0]};
    assign dmi_buf_wdata_o = req_data_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= dmi_pkg::st_idle;
            haltreq_q   <= 1'b0;
            hartreset_q <= 1'b0;
            dmactive_q  <= 1'b0;
            cmd_start_q <= 1'b0;
            cmderr_q    <= hart_pkg::cmderr_none;
        end else begin
            cmd_start_q <= 1'b0;
            case (state_q)
                dmi_pkg::st_idle: begin
                    if (accept) begin
                        state_q <= dmi_pkg::st_respond;
                        if (dmctl_wr) begin
                            haltreq_q   <= req_data_i[31];
                            hartreset_q <= req_data_i[29];
                            dmactive_q  <= req_data_i[0];
                        end
                        if (is_wr && req_addr_i == dmi_pkg::reg_abstractcs) begin
                            cmderr_q <= hart_pkg::cmderr_e'(cmderr_q & ~req_data_i[10:8]);
                        end
                        if (is_wr && req_addr_i == dmi_pkg::reg_command &&
                            cmderr_q == hart_pkg::cmderr_none) begin
                            if (!halted_i) begin
                                cmderr_q <= hart_pkg::cmderr_halt_resume;
                            end else if (cmd_bad) begin
                                cmderr_q <= hart_pkg::cmderr_not_supported;
                            end else if (req_data_i[17]) begin   // transfer
                                state_q     <= dmi_pkg::st_cmd_busy;
                                cmd_start_q <= 1'b1;
                            end
                        end
                    end
                end
                dmi_pkg::st_cmd_busy: if (cmd_done_i) state_q <= dmi_pkg::st_respond;
                default: if (resp_ready_i) state_q <= dmi_pkg::st_idle;
            endcase
        end
    end

    // Sticky status and resume request
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            resumereq_q <= 1'b0;
            resumeack_q <= 1'b0;
            havereset_q <= 1'b0;
            unavail_q   <= 1'b0;
        end else begin
            resumereq_q <= resume_wr || (resumereq_q && !resume_ack_i);
            resumeack_q <= resume_wr ? 1'b0 : (resumeack_q || resume_ack_i);
            havereset_q <= (dmctl_wr && req_data_i[28]) ? 1'b0 : (havereset_q || havereset_i);
            unavail_q   <= (dmctl_wr && req_data_i[27]) ? 1'b0 : (unavail_q || unavail_i);
        end
    end

    // Request word and response held until the handshake
    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_data_q  <= req_data_i;
            resp_data_q <= is_rd ? rd_data : '0;
            resp_op_q   <= (is_wr && req_addr_i == dmi_pkg::reg_sbcs) ? dmi_pkg::dmi_failed
                                                                       : dmi_pkg::dmi_success;
        end
    end

    assign req_ready_o      = state_q == dmi_pkg::st_idle;
    assign resp_valid_o     = state_q == dmi_pkg::st_respond;
    assign resp_data_o      = resp_data_q;
    assign resp_op_o        = resp_op_q;
    assign halt_request_o   = haltreq_q;
    assign resume_request_o = resumereq_q;
    assign hart_reset_o     = hartreset_q;

    assign cmd_start_o = cmd_start_q;
    assign cmd_lreg_o  = req_data_q[`DM_LREG_BITS-1:0];
    assign cmd_write_o = req_data_q[16];
    assign cmd_wide_o  = req_data_q[22:20] == 3'd3;   // aarsize 64 bit

endmodule

// File: logic/dm_top.sv
// Debug module top level
`timescale 1ns/1ps

module dm_top (
    input  logic               clk_i,
    input  logic               rstn_i,
    // DMI request and response
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  dmi_pkg::dmi_addr_t req_addr_i,
    input  dmi_pkg::dmi_data_t req_data_i,
    input  dmi_pkg::dmi_op_t   req_op_i,
    output logic               resp_valid_o,
    input  logic               resp_ready_i,
    output dmi_pkg::dmi_data_t resp_data_o,
    output dmi_pkg::dmi_op_t   resp_op_o,
    // Run control
    output logic               halt_request_o,
    output logic               resume_request_o,
    output logic               hart_reset_o,
    input  logic               resume_ack_i,
    input  logic               running_i,
    input  logic               halted_i,
    input  logic               havereset_i,
    input  logic               unavail_i,
    // Rename table and register file
    output logic               rnm_read_en_o,
    output hart_pkg::lreg_t    rnm_read_reg_o,
    input  hart_pkg::preg_t    rnm_read_resp_i,
    output logic               rf_en_o,
    output hart_pkg::preg_t    rf_preg_o,
    input  hart_pkg::xlen_t    rf_rdata_i,
    output logic               rf_we_o,
    output hart_pkg::xlen_t    rf_wdata_o,
    // Instruction fetch from the buffer
    input  logic               fetch_en_i,
    input  hart_pkg::buf_idx_t fetch_addr_i,
    output dmi_pkg::dmi_data_t fetch_rdata_o
);

    logic               cmd_start;
    hart_pkg::lreg_t    cmd_lreg;
    logic               cmd_write;
    logic               cmd_wide;
    logic               cmd_done;
    logic               dmi_buf_we;
    hart_pkg::buf_idx_t dmi_buf_idx;
    dmi_pkg::dmi_data_t dmi_buf_wdata;
    dmi_pkg::dmi_data_t buf_rdata;
    hart_pkg::xlen_t    cmd_data_in;
    logic               cmd_buf_we;
    logic               cmd_buf_wide;
    hart_pkg::xlen_t    cmd_buf_wdata;

    dm_dmi_regs u_dmi_regs (
        .clk_i, .rstn_i,
        .req_valid_i, .req_addr_i, .req_data_i, .req_op_i, .req_ready_o,
        .resp_ready_i, .resp_valid_o, .resp_data_o, .resp_op_o,
        .resume_ack_i, .running_i, .halted_i, .havereset_i, .unavail_i,
        .halt_request_o, .resume_request_o, .hart_reset_o,
        .cmd_done_i      (cmd_done),
        .buf_rdata_i     (buf_rdata),
        .cmd_start_o     (cmd_start),
        .cmd_lreg_o      (cmd_lreg),
        .cmd_write_o     (cmd_write),
        .cmd_wide_o      (cmd_wide),
        .dmi_buf_we_o    (dmi_buf_we),
        .dmi_buf_idx_o   (dmi_buf_idx),
        .dmi_buf_wdata_o (dmi_buf_wdata)
    );

    dm_abstract_cmd u_abstract_cmd (
        .clk_i, .rstn_i,
        .cmd_start_i     (cmd_start),
        .cmd_lreg_i      (cmd_lreg),
        .cmd_write_i     (cmd_write),
        .cmd_wide_i      (cmd_wide),
        .cmd_data_in_i   (cmd_data_in),
        .rnm_read_resp_i, .rf_rdata_i,
        .cmd_done_o      (cmd_done),
        .rnm_read_en_o, .rnm_read_reg_o,
        .rf_en_o, .rf_preg_o, .rf_we_o, .rf_wdata_o,
        .cmd_buf_we_o    (cmd_buf_we),
        .cmd_buf_wide_o  (cmd_buf_wide),
        .cmd_buf_wdata_o (cmd_buf_wdata)
    );

    dm_buffer_mem u_buffer_mem (
        .clk_i, .rstn_i,
        .dmi_buf_we_i    (dmi_buf_we),
        .dmi_buf_idx_i   (dmi_buf_idx),
        .dmi_buf_wdata_i (dmi_buf_wdata),
        .cmd_buf_we_i    (cmd_buf_we),
        .cmd_buf_wide_i  (cmd_buf_wide),
        .cmd_buf_wdata_i (cmd_buf_wdata),
        .fetch_en_i, .fetch_addr_i,
        .buf_rdata_o     (buf_rdata),
        .cmd_data_in_o   (cmd_data_in),
        .fetch_rdata_o
    );

endmodule

// File: tb/dm_checker.sv
// Debug module protocol checker
`timescale 1ns/1ps

module dm_checker (
    input logic               clk_i,
    input logic               rstn_i,
    input logic               req_ready_i,
    input logic               resp_valid_i,
    input logic               resp_ready_i,
    input dmi_pkg::dmi_data_t resp_data_i,
    input dmi_pkg::dmi_op_t   resp_op_i,
    input logic               rnm_read_en_i,
    input logic               rf_en_i,
    input logic               rf_we_i
);

    int fail_count = 0;   // Failed assertions so far

    // Response held stable until the debugger takes it
    resp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_i && !resp_ready_i |=>
            resp_valid_i && $stable(resp_data_i) && $stable(resp_op_i))
    else begin
        fail_count++;
        $error("response dropped or changed before resp_ready");
    end

    one_side: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(req_ready_i && resp_valid_i))
    else begin
        fail_count++;
        $error("request ready while a response is pending");
    end

    rf_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(rf_en_i && rf_we_i))
    else begin
        fail_count++;
        $error("register file read and write in the same cycle");
    end

    // Register file step follows the rename step
    rf_after_rnm: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (rf_en_i || rf_we_i) |-> $past(rnm_read_en_i))
    else begin
        fail_count++;
        $error("register file access without a rename lookup before it");
    end

endmodule

bind dm_top dm_checker u_checker (
    .clk_i, .rstn_i,
    .req_ready_i   (req_ready_o),
    .resp_valid_i  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .resp_data_i   (resp_data_o),
    .resp_op_i     (resp_op_o),
    .rnm_read_en_i (rnm_read_en_o),
    .rf_en_i       (rf_en_o),
    .rf_we_i       (rf_we_o)
);

// File: tb/dm_tb.sv
// Debug module testbench
`timescale 1ns/1ps
`include "dm_consts.svh"

module dm_tb;

    logic               clk, rstn;
    logic               req_valid, req_ready, resp_valid, resp_ready;
    dmi_pkg::dmi_addr_t req_addr;
    dmi_pkg::dmi_data_t req_data, resp_data, fetch_rdata;
    dmi_pkg::dmi_op_t   req_op, resp_op;
    logic               halt_req, resume_req, hart_reset;
    logic               resume_ack, running, halted, havereset, unavail;
    logic               rnm_en, rf_en, rf_we, fetch_en;
    hart_pkg::lreg_t    rnm_reg;
    hart_pkg::preg_t    rnm_resp, rf_preg;
    hart_pkg::xlen_t    rf_rdata, rf_wdata;
    hart_pkg::buf_idx_t fetch_addr;

    hart_pkg::xlen_t    hart_rf [64];   // Register file seen by the DUT
    hart_pkg::xlen_t    model_rf [64];
    dmi_pkg::dmi_data_t model_buf [`DM_BUF_WORDS];
    logic               m_haltreq, m_hartreset, m_dmactive, m_resumereq;
    logic               m_resumeack, m_havereset, m_unavail;
    logic [2:0]         m_cmderr;
    logic [31:0]        rng;
    dmi_pkg::dmi_addr_t addr_list [12] = '{7'h04, 7'h05, 7'h10, 7'h11, 7'h12, 7'h16,
                                           7'h17, 7'h20, 7'h21, 7'h22, 7'h23, 7'h38};

    dm_top uut (
        .clk_i(clk), .rstn_i(rstn),
        .req_valid_i(req_valid), .req_ready_o(req_ready), .req_addr_i(req_addr),
        .req_data_i(req_data), .req_op_i(req_op),
        .resp_valid_o(resp_valid), .resp_ready_i(resp_ready), .resp_data_o(resp_data),
        .resp_op_o(resp_op),
        .halt_request_o(halt_req), .resume_request_o(resume_req), .hart_reset_o(hart_reset),
        .resume_ack_i(resume_ack), .running_i(running), .halted_i(halted),
        .havereset_i(havereset), .unavail_i(unavail),
        .rnm_read_en_o(rnm_en), .rnm_read_reg_o(rnm_reg), .rnm_read_resp_i(rnm_resp),
        .rf_en_o(rf_en), .rf_preg_o(rf_preg), .rf_rdata_i(rf_rdata),
        .rf_we_o(rf_we), .rf_wdata_o(rf_wdata),
        .fetch_en_i(fetch_en), .fetch_addr_i(fetch_addr), .fetch_rdata_o(fetch_rdata)
    );

    always #10 clk = ~clk;

    // Hart model with a fixed rename table
    assign rnm_resp = rnm_en ? hart_pkg::preg_t'(rnm_reg) + 6'd32 : '0;
    assign rf_rdata = rf_en ? hart_rf[rf_preg] : '0;   // Answers only while enabled

    always @(posedge clk) begin
        if (rf_we) begin
            hart_rf[rf_preg] <= rf_wdata;
        end
    end

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (exp !== got) begin
            abort_run($sformatf("Error %s expected %h got %h", name, exp, got));
        end
    endtask

    always @(negedge clk) begin
        if (uut.u_checker.fail_count != 0) begin
            abort_run("A protocol assertion in the checker failed");
        end
    end

    // Buffer word behind a DMI address or -1 for none
    function automatic int buf_slot(input dmi_pkg::dmi_addr_t addr);
        if (addr >= 7'h20 && addr <= 7'h23) return int'(addr) - 32;
        if (addr == 7'h04 || addr == 7'h05) return int'(addr);
        return -1;
    endfunction

    function automatic dmi_pkg::dmi_data_t expect_read(input dmi_pkg::dmi_addr_t addr);
        dmi_pkg::dmi_data_t v;
        v = '0;
        if (addr == 7'h10) begin
            v[31] = m_haltreq;
            v[29] = m_hartreset;
            v[0]  = m_dmactive;
        end else if (addr == 7'h11) begin
            v[3:0]   = 4'd3;
            v[7]     = 1'b1;   // authenticated
            v[9:8]   = {2{halted}};
            v[11:10] = {2{running}};
            v[13:12] = {2{m_unavail}};
            v[17:16] = {2{m_resumeack}};
            v[19:18] = {2{m_havereset}};
        end else if (addr == 7'h16) begin
            v[3:0]   = 4'd2;
            v[10:8]  = m_cmderr;
            v[28:24] = 5'd4;
        end else if (buf_slot(addr) >= 0) begin
            v = model_buf[buf_slot(addr)];
        end
        return v;
    endfunction

    // Apply a DMI write to the model; returns the busy cycles it should cost
    task automatic model_write(input dmi_pkg::dmi_addr_t addr, input dmi_pkg::dmi_data_t d,
                               output int busy);
        int   preg;
        logic wide;
        busy = 0;
        preg = 32 + int'(d[4:0]);
        wide = d[22:20] == 3'd3;
        if (buf_slot(addr) >= 0) model_buf[buf_slot(addr)] = d;
        if (addr == 7'h10) begin
            if (d[30] && !d[31] && !m_haltreq) begin
                m_resumereq = 1'b1;
                m_resumeack = 1'b0;
            end
            if (d[28]) m_havereset = 1'b0;
            if (d[27]) m_unavail = 1'b0;
            m_haltreq   = d[31];
            m_hartreset = d[29];
            m_dmactive  = d[0];
        end else if (addr == 7'h16) begin
            m_cmderr = m_cmderr & ~d[10:8];
        end else if (addr == 7'h17 && m_cmderr == 3'd0) begin
            if (!halted) begin
                m_cmderr = 3'd4;
            end else if (d[31:24] != 8'd0 || d[15:0] < `DM_REGNO_GPR_FIRST ||
                         d[15:0] > `DM_REGNO_GPR_LAST || d[22:20] < 3'd2 ||
                         d[22:20] > 3'd3 || d[18]) begin
                m_cmderr = 3'd2;
            end else if (d[17] && d[16]) begin
                model_rf[preg] = wide ? {model_buf[5], model_buf[4]} : {32'b0, model_buf[4]};
                busy = 3;
            end else if (d[17]) begin
                model_buf[4] = model_rf[preg][31:0];
                if (wide) model_buf[5] = model_rf[preg][63:32];
                busy = 3;
            end
        end
    endtask

    // One DMI transaction entered and left at a falling edge
    task automatic dmi_access(input dmi_pkg::dmi_op_t op, input dmi_pkg::dmi_addr_t addr,
                              input dmi_pkg::dmi_data_t data, input int exp_busy,
                              output dmi_pkg::dmi_data_t rdata, output dmi_pkg::dmi_op_t rop);
        int cnt;
        int hold;
        cnt = 0;
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_data  = data;
        while (!req_ready) begin
            @(negedge clk);
            cnt++;
            if (cnt > 20) abort_run("Timeout waiting for the DUT to accept a request");
        end
        @(negedge clk);   // Accepted on the rising edge before
        req_valid = 1'b0;
        cnt = 0;
        while (!resp_valid) begin
            @(negedge clk);
            cnt++;
            if (cnt > 20) abort_run("Timeout waiting for a DMI response");
        end
        compare("busy cycles", exp_busy, cnt);
        rdata = resp_data;
        rop   = resp_op;
        hold  = int'(xorshift32() % 4);
        repeat (hold) begin
            @(negedge clk);
            compare("resp_valid_o", 1'b1, resp_valid);
            compare("resp_data_o", rdata, resp_data);
            compare("resp_op_o", rop, resp_op);
            compare("req_ready_o", 1'b0, req_ready);
        end
        resp_ready = 1'b1;
        @(negedge clk);
        resp_ready = 1'b0;
    endtask

    initial begin
        logic [31:0]        r, r2;
        int                 busy;
        dmi_pkg::dmi_addr_t a;
        dmi_pkg::dmi_data_t d, rd, exp_rd;
        dmi_pkg::dmi_op_t   op, rop;
        clk        = 1'b0;
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_data   = '0;
        req_op     = dmi_pkg::dmi_nop;
        resp_ready = 1'b0;
        resume_ack = 1'b0;
        running    = 1'b0;
        halted     = 1'b0;
        havereset  = 1'b0;
        unavail    = 1'b0;
        fetch_en   = 1'b0;
        fetch_addr = '0;
        rng        = 32'h3375_58ad;
        for (int i = 0; i < 64; i++) begin
            hart_rf[i]  = {32'(i) ^ 32'h5a5a_0000, 32'(i) * 32'h0104_0821 + 32'h1357};
            model_rf[i] = hart_rf[i];
        end
        for (int i = 0; i < `DM_BUF_WORDS; i++) model_buf[i] = '0;
        {m_haltreq, m_hartreset, m_dmactive, m_resumereq} = 4'b0;
        {m_resumeack, m_havereset, m_unavail, m_cmderr} = 6'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        compare("req_ready_o", 1'b1, req_ready);
        compare("resp_valid_o", 1'b0, resp_valid);
        compare("hart outputs", 6'b0, {halt_req, resume_req, hart_reset, rnm_en, rf_en, rf_we});

        for (int n = 0; n < 600; n++) begin
            r = xorshift32();
            halted     = r[1:0] != 2'd0;   // Mostly halted so commands can run
            running    = r[2];
            resume_ack = r[6:4] == 3'd0;
            havereset  = r[9:7] == 3'd0;
            unavail    = r[12:10] == 3'd0;
            fetch_en   = r[13];
            fetch_addr = r[16:14];
            @(negedge clk);
            if (resume_ack) begin
                m_resumereq = 1'b0;
                m_resumeack = 1'b1;
            end
            if (havereset) m_havereset = 1'b1;
            if (unavail) m_unavail = 1'b1;
            {resume_ack, havereset, unavail} = 3'b0;
            compare("resume_request_o", m_resumereq, resume_req);
            compare("fetch_rdata_o", !fetch_en ? 32'h0 :
                    (fetch_addr >= 3'd6) ? `DM_EBREAK : model_buf[fetch_addr], fetch_rdata);

            // Pick a register with extra weight on commands
            a  = (r[31:30] == 2'b00) ? 7'h17 : addr_list[r % 12];
            op = (r[29] || a == 7'h17) ? dmi_pkg::dmi_write : dmi_pkg::dmi_read;
            d  = xorshift32();
            r2 = xorshift32();
            if (a == 7'h16 && d[0]) d[10:8] = 3'b111;
            if (a == 7'h17) begin
                d        = '0;
                d[31:24] = (r2[2:0] == 3'd0) ? 8'd1 : 8'd0;
                d[22:20] = (r2[5:3] == 3'd0) ? 3'd1 : {2'b01, r2[6]};
                d[18]    = r2[9:7] == 3'd0;
                d[17]    = r2[11:10] != 2'd0;
                d[16]    = r2[12];
                d[15:0]  = (r2[15:13] == 3'd0) ? 16'h1020 : {11'h080, r2[20:16]};
            end
            exp_rd = expect_read(a);
            busy   = 0;
            if (op == dmi_pkg::dmi_write) model_write(a, d, busy);
            dmi_access(op, a, d, busy, rd, rop);
            if (op == dmi_pkg::dmi_read) compare("resp_data_o", exp_rd, rd);
            compare("resp_op_o", (op == dmi_pkg::dmi_write && a == 7'h38) ?
                    dmi_pkg::dmi_failed : dmi_pkg::dmi_success, rop);
            compare("halt_request_o", m_haltreq, halt_req);
            compare("hart_reset_o", m_hartreset, hart_reset);
            compare("resume_request_o", m_resumereq, resume_req);
        end

        for (int i = 0; i < 64; i++) begin
            compare($sformatf("hart_rf[%0d]", i), model_rf[i], hart_rf[i]);
        end
        if (uut.u_checker.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run("Protocol checker reported assertion failures");
        end
    end

endmodule

// File: compile.f
+incdir+logic
logic/dmi_pkg.sv
logic/hart_pkg.sv
logic/dm_buffer_mem.sv
logic/dm_abstract_cmd.sv
logic/dm_dmi_regs.sv
logic/dm_top.sv
tb/dm_checker.sv
tb/dm_tb.sv
